/* flist.f */
source/branchPkg.sv
source/regCompare.sv
source/branchResolve.sv
source/branchUnit.sv
verif/tbBranchUnit.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the branch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tbBranchUnit

if ! verilator --binary --timing -j 0 \
        --top-module "$TOP" \
        -f flist.f; then
    echo "Verilator build failed"
    exit 1
fi

if [ ! -x "obj_dir/V$TOP" ]; then
    echo "Simulation binary not found"
    exit 1
fi

output=$("./obj_dir/V$TOP" 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -Fqx "Finished with no errors" <<< "$output"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* source/branchPkg.sv */
package branchPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    // Register and address width
    localparam int DataWidth = 32;
    // Branch offset, counted in 32-bit words
    localparam int OffsetWidth = 16;

    //////////////////////////////////////////////////////////////////////
    // Branch kinds
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        opBeq  = 4'd0,
        opBne  = 4'd1,
        opBlt  = 4'd2,
        opBgt  = 4'd3,
        opBltz = 4'd4,
        opBgtz = 4'd5,
        opBlez = 4'd6,
        opBgez = 4'd7,
        // Register jump, target comes from rs1
        opJr   = 4'd8
    } branchOpT;

    //////////////////////////////////////////////////////////////////////
    // Decode to branch unit
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [DataWidth-1:0]   pc;
        branchOpT               op;
        logic [DataWidth-1:0]   rs1;
        logic [DataWidth-1:0]   rs2;
        // Signed word offset, relative to pc plus 4
        logic [OffsetWidth-1:0] offset;
        // Fetch guessed taken
        logic                   predTaken;
    } branchReqT;

    // Comparator output
    typedef struct packed {
        // Operands equal
        logic eq;
        // Signed order of rs1 against rs2
        logic lt;
        logic gt;
        // Status of rs1 alone
        logic zero;
        logic ltz;
        logic gtz;
    } cmpFlagsT;

    //////////////////////////////////////////////////////////////////////
    // Branch unit to fetch
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [DataWidth-1:0] pc;
        logic                 taken;
        logic                 mispredict;
        // Target when taken, else pc plus 4
        logic [DataWidth-1:0] nextPc;
    } branchResT;

endpackage

/* source/branchResolve.sv */
module branchResolve (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 reqValid,
    input  branchPkg::branchReqT req,
    input  branchPkg::cmpFlagsT  flags,
    output logic                 resultValid,
    output branchPkg::branchResT result,
    output logic                 redirect
);
    import branchPkg::*;

    // Taken decision for the current request
    logic taken;

    // Candidate next addresses
    logic [DataWidth-1:0] pcPlus4;
    logic [DataWidth-1:0] offsetBytes;
    logic [DataWidth-1:0] branchTarget;
    logic [DataWidth-1:0] jrTarget;
    logic [DataWidth-1:0] nextPc;

    logic mispredict;

    // Outcome before the register
    branchResT resolved;

    //////////////////////////////////////////////////////////////////////
    // Condition select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (req.op)
            opBeq: begin
                taken = flags.eq;
            end
            opBne: begin
                taken = !flags.eq;
            end
            opBlt: begin
                taken = flags.lt;
            end
            opBgt: begin
                taken = flags.gt;
            end
            opBltz: begin
                taken = flags.ltz;
            end
            opBgtz: begin
                taken = flags.gtz;
            end
            opBlez: begin
                taken = flags.ltz || flags.zero;
            end
            opBgez: begin
                taken = !flags.ltz;
            end
            opJr: begin
                taken = 1'b1;
            end
            default: begin
                // Unused encodings never redirect
                taken = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Target and fall-through
    //////////////////////////////////////////////////////////////////////

    assign pcPlus4 = req.pc + DataWidth'(4);

    // Word offset, sign extended and scaled to bytes
    assign offsetBytes = {
        {(DataWidth - OffsetWidth - 2){req.offset[OffsetWidth-1]}},
        req.offset,
        2'b00
    };

    // Wraps at 32 bits
    assign branchTarget = pcPlus4 + offsetBytes;

    // Register jump keeps word alignment
    assign jrTarget = {req.rs1[DataWidth-1:2], 2'b00};

    always_comb begin
        if (!taken) begin
            nextPc = pcPlus4;
        end else if (req.op == opJr) begin
            nextPc = jrTarget;
        end else begin
            nextPc = branchTarget;
        end
    end

    assign mispredict = taken != req.predTaken;

    always_comb begin
        resolved            = '0;
        resolved.pc         = req.pc;
        resolved.taken      = taken;
        resolved.mispredict = mispredict;
        resolved.nextPc     = nextPc;
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
            redirect    <= 1'b0;
        end else begin
            resultValid <= reqValid;
            // Flush pulse only for a real, wrongly guessed branch
            redirect    <= reqValid && mispredict;
        end
    end

    // Result holds its last value through idle cycles
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
        end else if (reqValid) begin
            result <= resolved;
        end
    end

endmodule

/* source/branchUnit.sv */
module branchUnit (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 reqValid,
    input  branchPkg::branchReqT req,
    output logic                 resultValid,
    output branchPkg::branchResT result,
    output logic                 redirect
);
    import branchPkg::*;

    // Comparator flags, same cycle as the request
    cmpFlagsT flags;

    //////////////////////////////////////////////////////////////////////
    // Operand comparison
    //////////////////////////////////////////////////////////////////////

    regCompare i_regCompare (
        .rs1   (req.rs1),
        .rs2   (req.rs2),
        .flags (flags)
    );

    //////////////////////////////////////////////////////////////////////
    // Decision and result register
    //////////////////////////////////////////////////////////////////////

    branchResolve i_branchResolve (
        .clk         (clk),
        .arstN       (arstN),
        .reqValid    (reqValid),
        .req         (req),
        .flags       (flags),
        .resultValid (resultValid),
        .result      (result),
        .redirect    (redirect)
    );

endmodule

/* source/regCompare.sv */
module regCompare (
    input  logic [branchPkg::DataWidth-1:0] rs1,
    input  logic [branchPkg::DataWidth-1:0] rs2,
    output branchPkg::cmpFlagsT             flags
);
    import branchPkg::*;

    // Sign bits of the two operands
    logic sign1;
    logic sign2;
    logic signsDiffer;

    // Order of the bits below the sign
    logic lowLess;
    logic lowEqual;

    // rs1 status
    logic rs1Zero;

    assign sign1       = rs1[DataWidth-1];
    assign sign2       = rs2[DataWidth-1];
    assign signsDiffer = sign1 ^ sign2;

    // With equal signs, two's complement order matches the order
    // of the remaining bits, for negative values as well
    assign lowLess  = rs1[DataWidth-2:0] < rs2[DataWidth-2:0];
    assign lowEqual = rs1[DataWidth-2:0] == rs2[DataWidth-2:0];

    assign rs1Zero = (rs1 == '0);

    //////////////////////////////////////////////////////////////////////
    // Operand order
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        flags = '0;

        if (signsDiffer) begin
            // Negative operand is the smaller one
            flags.lt = sign1;
            flags.gt = sign2;
        end else if (lowEqual) begin
            flags.eq = 1'b1;
        end else begin
            flags.lt = lowLess;
            flags.gt = !lowLess;
        end

        // Single operand tests on rs1
        flags.zero = rs1Zero;
        flags.ltz  = sign1;
        flags.gtz  = !sign1 && !rs1Zero;
    end

endmodule

/* verif/tbBranchUnit.sv */
module tbBranchUnit;
    timeunit 1ns;
    timeprecision 1ps;

    import branchPkg::*;

    localparam int ResetCycles   = 5;
    localparam int NumCycles     = 500;
    // Reset, two idle checks, the random run and the drain
    localparam int PlannedCycles = ResetCycles + 2 + NumCycles + 2;
    localparam int TimeoutLimit  = PlannedCycles + 20;

    logic      clk;
    logic      arstN;
    logic      reqValid;
    branchReqT req;
    logic      resultValid;
    branchResT result;
    logic      redirect;

    logic [15:0] lfsrState;
    int          cycleCount;
    int          resultCount;

    // Expected outcome for the cycle after each drive
    logic      expValidQ[$];
    branchResT expResQ[$];

    branchUnit i_dut (
        .clk         (clk),
        .arstN       (arstN),
        .reqValid    (reqValid),
        .req         (req),
        .resultValid (resultValid),
        .result      (result),
        .redirect    (redirect)
    );

    always #10 clk = !clk;

    //////////////////////////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////////////////////////

    // Taps 16, 14, 13, 11 give a maximal length sequence
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        logic        feedback;
        int          k;
        value = '0;
        for (k = 0; k < n; k++) begin
            feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value     = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Zero, negative and small values come up often
    function automatic logic [31:0] pickOperand();
        logic [1:0]  kind;
        logic        sign;
        logic [7:0]  low;
        logic [31:0] value;
        kind = 2'(randBits(2));
        case (kind)
            2'd0: value = '0;
            2'd1: value = randBits(32) | 32'h8000_0000;
            2'd2: value = randBits(32);
            default: begin
                sign  = 1'(randBits(1));
                low   = 8'(randBits(8));
                value = {{24{sign}}, low};
            end
        endcase
        return value;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic branchResT modelResolve(input branchReqT r);
        branchResT   res;
        logic        taken;
        logic [31:0] seqPc;
        logic [31:0] offsetWords;
        logic [31:0] target;
        seqPc       = r.pc + 32'd4;
        offsetWords = 32'($signed(r.offset));
        target      = seqPc + (offsetWords << 2);
        case (r.op)
            opBeq:   taken = r.rs1 == r.rs2;
            opBne:   taken = r.rs1 != r.rs2;
            opBlt:   taken = $signed(r.rs1) < $signed(r.rs2);
            opBgt:   taken = $signed(r.rs1) > $signed(r.rs2);
            opBltz:  taken = $signed(r.rs1) < 32'sd0;
            opBgtz:  taken = $signed(r.rs1) > 32'sd0;
            opBlez:  taken = $signed(r.rs1) <= 32'sd0;
            opBgez:  taken = $signed(r.rs1) >= 32'sd0;
            opJr:    taken = 1'b1;
            default: taken = 1'b0;
        endcase
        res            = '0;
        res.pc         = r.pc;
        res.taken      = taken;
        res.mispredict = taken != r.predTaken;
        if (!taken) begin
            res.nextPc = seqPc;
        end else if (r.op == opJr) begin
            res.nextPc = r.rs1 & ~32'd3;
        end else begin
            res.nextPc = target;
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic failRun();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: expected %b, actual %b", $time, name, expected, actual);
            failRun();
        end
    endtask

    task automatic checkResult(input string name, input branchResT expected,
                               input branchResT actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: expected %h, actual %h", $time, name, expected, actual);
            $display("  pc %h/%h taken %b/%b mispredict %b/%b nextPc %h/%h",
                     expected.pc, actual.pc, expected.taken, actual.taken,
                     expected.mispredict, actual.mispredict,
                     expected.nextPc, actual.nextPc);
            failRun();
        end
    endtask

    // Compare outputs with the oldest expectation
    task automatic checkCycle();
        logic      expValid;
        branchResT expRes;
        expValid = expValidQ.pop_front();
        expRes   = expResQ.pop_front();
        checkBit("resultValid", expValid, resultValid);
        checkBit("redirect", expValid && expRes.mispredict, redirect);
        if (expValid) begin
            checkResult("result", expRes, result);
            resultCount++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic driveCycle();
        branchReqT  r;
        logic       sendIt;
        logic [1:0] rs2Kind;
        logic [2:0] pcKind;
        logic [7:0] pcLow;
        sendIt  = 2'(randBits(2)) != 2'd0;
        pcKind  = 3'(randBits(3));
        // Some addresses sit near the top so targets wrap
        if (pcKind == 3'd0) begin
            pcLow = 8'(randBits(8));
            r.pc  = {24'hFF_FFFF, pcLow[7:2], 2'b00};
        end else begin
            r.pc = randBits(32) & ~32'd3;
        end
        r.op  = branchOpT'(4'(randBits(4) % 32'd9));
        r.rs1 = pickOperand();
        rs2Kind = 2'(randBits(2));
        case (rs2Kind)
            2'd0: r.rs2 = r.rs1;
            2'd1: r.rs2 = -r.rs1;
            default: r.rs2 = pickOperand();
        endcase
        r.offset    = 16'(randBits(16));
        r.predTaken = 1'(randBits(1));
        // Idle cycles still carry a payload
        reqValid = sendIt;
        req      = r;
        expValidQ.push_back(sendIt);
        expResQ.push_back(sendIt ? modelResolve(r) : branchResT'('0));
    endtask

    always @(posedge clk) begin
        if (cycleCount >= TimeoutLimit) begin
            $display("Timeout: the run did not end within %0d cycles", TimeoutLimit);
            failRun();
        end else begin
            cycleCount++;
        end
    end

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        reqValid    = 1'b0;
        req         = '0;
        lfsrState   = 16'd61551;
        cycleCount  = 0;
        resultCount = 0;

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // Outputs stay cleared until the first request
        checkBit("resultValid", 1'b0, resultValid);
        checkBit("redirect", 1'b0, redirect);
        checkResult("result", '0, result);
        @(negedge clk);
        checkBit("resultValid", 1'b0, resultValid);
        checkBit("redirect", 1'b0, redirect);
        checkResult("result", '0, result);

        for (int i = 0; i < NumCycles; i++) begin
            driveCycle();
            @(negedge clk);
            checkCycle();
        end

        // Drain with one idle cycle
        reqValid = 1'b0;
        expValidQ.push_back(1'b0);
        expResQ.push_back('0);
        @(negedge clk);
        checkCycle();

        $display("Checked %0d results over %0d cycles", resultCount, NumCycles);
        $display("Finished with no errors");
        $finish;
    end

endmodule
